// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int ADDR_W = 16;    // word address, CPU and memory
    localparam int DATA_W = 32;    // one word per line

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // controller states
    typedef enum logic [2:0]
    {
        IDLE            = 3'd0,
        PROCESS_REQUEST = 3'd1,
        CACHE_ALLOCATE  = 3'd2,
        WRITEBACK       = 3'd3,
        FLUSH           = 3'd4
    } cache_state_t;

endpackage

`default_nettype wire

// ==== hw/cache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_controller
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cpu_req_i,
    input  wire logic cpu_we_i,
    input  wire logic flush_i,
    input  wire logic hit_i,
    input  wire logic dirty_i,
    input  wire logic flush_done_i,
    input  wire logic mem_ack_i,
    output logic      wr_en_o,
    output logic      rd_en_o,
    output logic      fill_en_o,
    output logic      mem_rd_o,
    output logic      mem_wr_o,
    output logic      cache_clean_o,
    output logic      cpu_ack_o,
    output logic      stall_o
);

    import cache_pkg::*;

    cache_state_t c_state;
    cache_state_t n_state;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            c_state <= IDLE;
        else
            c_state <= n_state;
    end

    always_comb
    begin
        n_state = c_state;
        case (c_state)
            IDLE:
            begin
                if (cpu_req_i)                 // request wins over flush
                    n_state = PROCESS_REQUEST;
                else if (flush_i)
                    n_state = FLUSH;
            end
            PROCESS_REQUEST:
            begin
                if (hit_i)
                    n_state = IDLE;
                else if (dirty_i)
                    n_state = WRITEBACK;       // victim goes out first
                else
                    n_state = CACHE_ALLOCATE;
            end
            CACHE_ALLOCATE:
            begin
                if (mem_ack_i)
                    n_state = PROCESS_REQUEST; // replay as a hit
            end
            WRITEBACK:
            begin
                if (mem_ack_i)
                begin
                    if (flush_i)
                        n_state = FLUSH;
                    else
                        n_state = CACHE_ALLOCATE;
                end
            end
            FLUSH:
            begin
                if (flush_done_i)
                    n_state = IDLE;
                else if (dirty_i)
                    n_state = WRITEBACK;
            end
            default:
            begin
                n_state = IDLE;
            end
        endcase
    end

    always_comb
    begin
        wr_en_o       = 1'b0;
        rd_en_o       = 1'b0;
        fill_en_o     = 1'b0;
        mem_rd_o      = 1'b0;
        mem_wr_o      = 1'b0;
        cache_clean_o = 1'b0;
        cpu_ack_o     = 1'b0;
        stall_o       = 1'b1;
        case (c_state)
            IDLE:
            begin
                stall_o = cpu_req_i;
            end
            PROCESS_REQUEST:
            begin
                if (hit_i)
                begin
                    cpu_ack_o = 1'b1;
                    if (cpu_we_i)
                        wr_en_o = 1'b1;
                    else
                        rd_en_o = 1'b1;
                end
                else if (dirty_i)
                    mem_wr_o = 1'b1;
                else
                    mem_rd_o = 1'b1;
            end
            CACHE_ALLOCATE:
            begin
                if (mem_ack_i)
                    fill_en_o = 1'b1;          // line written from mem_rdata
                else
                    mem_rd_o = 1'b1;
            end
            WRITEBACK:
            begin
                if (mem_ack_i)
                begin
                    if (flush_i)
                        cache_clean_o = 1'b1;  // scanned line now clean
                    else
                        mem_rd_o = 1'b1;
                end
                else
                    mem_wr_o = 1'b1;
            end
            FLUSH:
            begin
                if (flush_done_i)
                    cpu_ack_o = 1'b1;
                else if (dirty_i)
                    mem_wr_o = 1'b1;
                else
                    cache_clean_o = 1'b1;      // skip clean line
            end
            default:
            begin
                stall_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cache_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_store
#(
    parameter int INDEX_W = 4
)
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cache_pkg::addr_t cpu_addr_i,
    input  wire cache_pkg::data_t cpu_wdata_i,
    input  wire logic             wr_en_i,
    input  wire logic             rd_en_i,
    input  wire logic             fill_en_i,
    input  wire logic             cache_clean_i,
    input  wire logic             mem_wr_i,
    input  wire logic             flushing_i,
    input  wire cache_pkg::data_t mem_rdata_i,
    output cache_pkg::data_t      cpu_rdata_o,
    output logic                  hit_o,
    output logic                  dirty_o,
    output logic                  flush_done_o,
    output cache_pkg::addr_t      mem_addr_o,
    output cache_pkg::data_t      mem_wdata_o
);

    import cache_pkg::*;

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W;

    data_t              data_mem [LINES];
    logic [TAG_W-1:0]   tag_mem  [LINES];
    logic [LINES-1:0]   valid_q;
    logic [LINES-1:0]   dirty_q;
    logic [INDEX_W:0]   scan_q;        // extra bit marks end of scan

    logic [INDEX_W-1:0] req_idx;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] scan_idx;
    logic [INDEX_W-1:0] wb_idx;

    assign req_idx  = cpu_addr_i[INDEX_W-1:0];
    assign req_tag  = cpu_addr_i[ADDR_W-1:INDEX_W];
    assign scan_idx = scan_q[INDEX_W-1:0];

    // line that a writeback would send out
    assign wb_idx = flushing_i ? scan_idx : req_idx;

    assign hit_o        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign dirty_o      = dirty_q[wb_idx];
    assign flush_done_o = scan_q[INDEX_W];

    assign cpu_rdata_o = rd_en_i ? data_mem[req_idx] : '0;
    assign mem_wdata_o = data_mem[wb_idx];

    // victim address on writeback, request address on allocate
    always_comb
    begin
        if (mem_wr_i)
            mem_addr_o = {tag_mem[wb_idx], wb_idx};
        else
            mem_addr_o = cpu_addr_i;
    end

    always_ff @(posedge clk)
    begin
        if (fill_en_i)
        begin
            data_mem[req_idx] <= mem_rdata_i;
            tag_mem[req_idx]  <= req_tag;
        end
        else if (wr_en_i)
            data_mem[req_idx] <= cpu_wdata_i;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill_en_i)
        begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;  // fresh copy of memory
        end
        else if (wr_en_i)
            dirty_q[req_idx] <= 1'b1;
        else if (cache_clean_i)
            dirty_q[scan_idx] <= 1'b0;
    end

    // flush scan pointer
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            scan_q <= '0;
        else if (flush_done_o)
            scan_q <= '0;              // done is taken by the FSM this cycle
        else if (cache_clean_i)
            scan_q <= scan_q + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_top
#(
    parameter int INDEX_W = 4
)
(
    input  wire logic             clk,
    input  wire logic             rst,
    // CPU side
    input  wire logic             cpu_req_i,
    input  wire logic             cpu_we_i,
    input  wire cache_pkg::addr_t cpu_addr_i,
    input  wire cache_pkg::data_t cpu_wdata_i,
    input  wire logic             flush_i,
    output cache_pkg::data_t      cpu_rdata_o,
    output logic                  cpu_ack_o,
    output logic                  stall_o,
    // main memory side
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output cache_pkg::addr_t      mem_addr_o,
    output cache_pkg::data_t      mem_wdata_o,
    input  wire cache_pkg::data_t mem_rdata_i,
    input  wire logic             mem_ack_i
);

    logic wr_en;
    logic rd_en;
    logic fill_en;
    logic cache_clean;
    logic hit;
    logic dirty;
    logic flush_done;

    cache_controller cache_controller_i
    (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_i     (cpu_req_i),
        .cpu_we_i      (cpu_we_i),
        .flush_i       (flush_i),
        .hit_i         (hit),
        .dirty_i       (dirty),
        .flush_done_i  (flush_done),
        .mem_ack_i     (mem_ack_i),
        .wr_en_o       (wr_en),
        .rd_en_o       (rd_en),
        .fill_en_o     (fill_en),
        .mem_rd_o      (mem_rd_o),
        .mem_wr_o      (mem_wr_o),
        .cache_clean_o (cache_clean),
        .cpu_ack_o     (cpu_ack_o),
        .stall_o       (stall_o)
    );

    cache_store
    #(
        .INDEX_W (INDEX_W)
    )
    cache_store_i
    (
        .clk           (clk),
        .rst           (rst),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_wdata_i   (cpu_wdata_i),
        .wr_en_i       (wr_en),
        .rd_en_i       (rd_en),
        .fill_en_i     (fill_en),
        .cache_clean_i (cache_clean),
        .mem_wr_i      (mem_wr_o),     // picks the victim address
        .flushing_i    (flush_i),
        .mem_rdata_i   (mem_rdata_i),
        .cpu_rdata_o   (cpu_rdata_o),
        .hit_o         (hit),
        .dirty_o       (dirty),
        .flush_done_o  (flush_done),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o)
    );

endmodule

`default_nettype wire

// ==== testbench/main_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module main_mem_model
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             mem_rd_i,
    input  wire logic             mem_wr_i,
    input  wire cache_pkg::addr_t mem_addr_i,
    input  wire cache_pkg::data_t mem_wdata_i,
    output cache_pkg::data_t      mem_rdata_o,
    output logic                  mem_ack_o
);

    import cache_pkg::*;

    localparam logic [15:0] MEM_FILL_TAG = 16'hA5A5;

    data_t  mem    [65536];
    int     wr_cnt [65536];
    int     rd_total;
    integer seed;
    logic   busy;
    logic   is_wr;
    int     cnt;
    addr_t  cmd_addr;
    data_t  cmd_data;

    initial
    begin
        seed     = 32'h84184d0d;
        rd_total = 0;
        for (int a = 0; a < 65536; a++)
        begin
            mem[a]    = {MEM_FILL_TAG, a[15:0]};   // tag high, own address low
            wr_cnt[a] = 0;
        end
    end

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mem_ack_o   <= 1'b0;
            mem_rdata_o <= '0;
            busy        <= 1'b0;
            is_wr       <= 1'b0;
            cnt         <= 0;
        end
        else
        begin
            mem_ack_o <= 1'b0;
            if (busy)
            begin
                if (cnt == 0)
                begin
                    mem_ack_o <= 1'b1;
                    busy      <= 1'b0;
                    if (is_wr)
                    begin
                        mem[cmd_addr]    <= cmd_data;
                        wr_cnt[cmd_addr] <= wr_cnt[cmd_addr] + 1;
                    end
                    else
                    begin
                        mem_rdata_o <= mem[cmd_addr];
                        rd_total    <= rd_total + 1;
                    end
                end
                else
                    cnt <= cnt - 1;
            end
            else if ((mem_rd_i || mem_wr_i) && !mem_ack_o)   // ignore the ack edge
            begin
                busy     <= 1'b1;
                is_wr    <= mem_wr_i;
                cmd_addr <= mem_addr_i;
                cmd_data <= mem_wdata_i;
                cnt      <= int'($unsigned($random(seed)) % 4);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/cache_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_assert
(
    input wire logic             clk,
    input wire logic             rst,
    input wire logic             mem_rd_i,
    input wire logic             mem_wr_i,
    input wire logic             mem_ack_i,
    input wire logic             cpu_ack_i,
    input wire logic             stall_i,
    input wire cache_pkg::addr_t mem_addr_i,
    input wire cache_pkg::data_t mem_wdata_i
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!rst) !(mem_rd_i && mem_wr_i))
        else
        begin
            $error("memory read and write together");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst) cpu_ack_i |-> stall_i)
        else
        begin
            $error("acknowledge without stall");
            fail_count++;
        end

    // command may drop in the ack cycle itself
    assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_i && !mem_ack_i) |=> (mem_ack_i || (mem_rd_i && $stable(mem_addr_i))))
        else
        begin
            $error("memory read dropped before ack");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst)
        (mem_wr_i && !mem_ack_i) |=> (mem_ack_i ||
            (mem_wr_i && $stable(mem_addr_i) && $stable(mem_wdata_i))))
        else
        begin
            $error("memory write dropped before ack");
            fail_count++;
        end

    assert property (@(posedge clk) !rst |-> !(mem_rd_i || mem_wr_i || cpu_ack_i || stall_i))
        else
        begin
            $error("control output high in reset");
            fail_count++;
        end

endmodule

bind cache_top cache_assert cache_assert_i
(
    .clk         (clk),
    .rst         (rst),
    .mem_rd_i    (mem_rd_o),
    .mem_wr_i    (mem_wr_o),
    .mem_ack_i   (mem_ack_i),
    .cpu_ack_i   (cpu_ack_o),
    .stall_i     (stall_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o)
);

`default_nettype wire

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

    import cache_pkg::*;

    localparam int INDEX_W = 4;
    localparam int LINES   = 1 << INDEX_W;
    localparam int TIMEOUT = 200;
    localparam logic [15:0] MEM_FILL_TAG = 16'hA5A5;

    logic  clk;
    logic  rst;
    logic  cpu_req;
    logic  cpu_we;
    logic  flush;
    addr_t cpu_addr;
    data_t cpu_wdata;
    data_t cpu_rdata;
    logic  cpu_ack;
    logic  stall;
    logic  mem_rd;
    logic  mem_wr;
    logic  mem_ack;
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;

    logic [31:0] pat [0:255];      // op, addr, wdata, expected per entry
    data_t exp_mem    [65536];
    int    exp_wr_cnt [65536];
    int    exp_rd_total;
    data_t line_data  [LINES];
    addr_t line_addr  [LINES];     // full address stands in for tag
    logic  line_valid [LINES];
    logic  line_dirty [LINES];
    int    errors;
    int    checks;
    int    op;
    logic  timed_out;

    always #4 clk = ~clk;

    cache_top #(.INDEX_W(INDEX_W)) cache_top_i
    (
        .clk (clk), .rst (rst),
        .cpu_req_i (cpu_req), .cpu_we_i (cpu_we), .cpu_addr_i (cpu_addr),
        .cpu_wdata_i (cpu_wdata), .flush_i (flush), .cpu_rdata_o (cpu_rdata),
        .cpu_ack_o (cpu_ack), .stall_o (stall), .mem_rd_o (mem_rd), .mem_wr_o (mem_wr),
        .mem_addr_o (mem_addr), .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata), .mem_ack_i (mem_ack)
    );

    main_mem_model main_mem_model_i
    (
        .clk (clk), .rst (rst), .mem_rd_i (mem_rd), .mem_wr_i (mem_wr),
        .mem_addr_i (mem_addr), .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata), .mem_ack_o (mem_ack)
    );

    task automatic check_value(input string what, input data_t got, input data_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_back_line(input int i);
        exp_mem[line_addr[i]]    = line_data[i];
        exp_wr_cnt[line_addr[i]] = exp_wr_cnt[line_addr[i]] + 1;
        line_dirty[i]            = 1'b0;
    endtask

    task automatic predict_access(input logic we, input addr_t a, input data_t wd,
                                  output data_t rd);
        int i;
        i = int'(a[INDEX_W-1:0]);
        if (!(line_valid[i] && line_addr[i] == a))
        begin
            if (line_valid[i] && line_dirty[i])
                write_back_line(i);                // victim out first
            line_data[i]  = exp_mem[a];
            line_addr[i]  = a;
            line_valid[i] = 1'b1;
            line_dirty[i] = 1'b0;
            exp_rd_total++;
        end
        if (we)
        begin
            line_data[i]  = wd;
            line_dirty[i] = 1'b1;
        end
        rd = line_data[i];
    endtask

    task automatic predict_flush();
        for (int i = 0; i < LINES; i++)
            if (line_valid[i] && line_dirty[i])
                write_back_line(i);
    endtask

    task automatic wait_ack(output logic got);
        int n;
        n   = 0;
        got = 1'b0;
        while (!got && n < TIMEOUT)
        begin
            @(negedge clk);
            if (cpu_ack)
                got = 1'b1;
            else
                n++;
        end
    endtask

    task automatic compare_memory();
        int bad;
        bad = 0;
        for (int a = 0; a < 65536; a++)
        begin
            if (main_mem_model_i.wr_cnt[a] != exp_wr_cnt[a] ||
                main_mem_model_i.mem[a] !== exp_mem[a])
            begin
                bad++;
                $display("Mismatch at %0t: memory %h holds %h after %0d writes, expected %h, %0d",
                         $time, a[15:0], main_mem_model_i.mem[a],
                         main_mem_model_i.wr_cnt[a], exp_mem[a], exp_wr_cnt[a]);
            end
        end
        checks++;
        errors = errors + bad;
        check_value("memory read count", data_t'(main_mem_model_i.rd_total),
                    data_t'(exp_rd_total));
    endtask

    task automatic run_op(input int n);
        logic [31:0] code;
        addr_t       a;
        data_t       wd;
        data_t       exp;
        data_t       got;
        data_t       model_rd;
        logic        acked;
        int          err0;
        code     = pat[n*4];
        a        = pat[n*4+1][15:0];
        wd       = pat[n*4+2];
        exp      = pat[n*4+3];
        err0     = errors;
        model_rd = '0;
        if (code == 32'd2)
        begin
            flush = 1'b1;
            predict_flush();
        end
        else
        begin
            cpu_req   = 1'b1;
            cpu_we    = code[0];
            cpu_addr  = a;
            cpu_wdata = wd;
            predict_access(code[0], a, wd, model_rd);
        end
        wait_ack(acked);
        if (!acked)
        begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout at %0t: op %0d got no acknowledge from the cache", $time, n);
        end
        else
        begin
            got = cpu_rdata;                       // valid in the ack cycle
            @(posedge clk);
            #1;
            cpu_req = 1'b0;
            cpu_we  = 1'b0;
            flush   = 1'b0;
            if (code == 32'd0)
            begin
                check_value("read data vs pattern", got, exp);
                check_value("read data vs model", got, model_rd);
            end
            compare_memory();
            $display("op %0d %s addr %h: %s", n,
                     code == 32'd0 ? "read" : (code == 32'd1 ? "write" : "flush"),
                     a, errors == err0 ? "ok" : "FAILED");
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b0;
        cpu_req      = 1'b0;
        cpu_we       = 1'b0;
        flush        = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        exp_rd_total = 0;
        for (int a = 0; a < 65536; a++)
        begin
            exp_mem[a]    = {MEM_FILL_TAG, a[15:0]};
            exp_wr_cnt[a] = 0;
        end
        for (int i = 0; i < LINES; i++)
        begin
            line_data[i]  = '0;
            line_addr[i]  = '0;
            line_valid[i] = 1'b0;
            line_dirty[i] = 1'b0;
        end
        $readmemh("testbench/cache_patterns.txt", pat);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            check_value("idle controls", data_t'({stall, cpu_ack, mem_rd, mem_wr}), '0);
        end
        $display("reset idle: %s", errors == 0 ? "ok" : "FAILED");
        @(posedge clk);
        #1;
        op = 0;
        while (!timed_out && pat[op*4] != 32'hF)
        begin
            run_op(op);
            op++;
        end
        if (cache_top_i.cache_assert_i.fail_count != 0)
        begin
            errors = errors + cache_top_i.cache_assert_i.fail_count;
            $display("%0d protocol assertions failed during the run",
                     cache_top_i.cache_assert_i.fail_count);
        end
        $display("ops %0d checks %0d errors %0d", op, checks, errors);
        if (errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/cache_patterns.txt ====
// op addr wdata expected  (op 0 read, 1 write, 2 flush, f end)
// expected is checked for reads only
0 0012 00000000 A5A50012
0 0012 00000000 A5A50012
1 0023 DEADBEEF 00000000
0 0023 00000000 DEADBEEF
0 0133 00000000 A5A50133
0 0023 00000000 DEADBEEF
1 0045 12345678 00000000
1 0046 CAFEF00D 00000000
1 0012 11112222 00000000
2 0000 00000000 00000000
2 0000 00000000 00000000
0 0045 00000000 12345678
0 0012 00000000 11112222
1 0ABF 55AA55AA 00000000
0 1ABF 00000000 A5A51ABF
0 0ABF 00000000 55AA55AA
f 0000 00000000 00000000

// ==== build.f ====
hw/cache_pkg.sv
hw/cache_controller.sv
hw/cache_store.sv
hw/cache_top.sv
testbench/main_mem_model.sv
testbench/cache_assert.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -f build.f -o Vcache_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vcache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
